// ==== design/sha256_defines.svh ====
/*
 * Shared constants for the pipelined SHA-256 core.
 * Included by the package and by modules that size logic from them.
 */

`ifndef SHA256_DEFINES_SVH
`define SHA256_DEFINES_SVH

// Pipeline depth, one register stage per round
`define SHA_ROUNDS 61

`define SHA_WORD_W 32
`define SHA_MSG_WORDS 8

// Padding for a single 256-bit message
`define SHA_PAD_WORD 32'h80000000
`define SHA_LEN_WORD 32'd256

`endif

// ==== design/sha256_pkg.sv ====
/*
 * Types, round constants and sigma helpers for the SHA-256 pipeline.
 * Imported by every module of the core.
 */

`default_nettype none

`include "sha256_defines.svh"

package sha256_pkg;

	typedef logic [`SHA_WORD_W-1:0] word_t;

	// Element 0 feeds the current round
	typedef word_t [15:0] window_t;

	typedef word_t [`SHA_MSG_WORDS-1:0] msg_t;

	typedef struct packed {
		word_t a;
		word_t b;
		word_t c;
		word_t d;
		word_t e;
		word_t f;
		word_t g;
		word_t h;
	} state_t;

	localparam word_t K_TABLE [64] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	function automatic word_t round_k(input int unsigned idx);
		return K_TABLE[idx];
	endfunction

	function automatic word_t rotr(input word_t x, input int unsigned n);
		return (x >> n) | (x << (`SHA_WORD_W - n));
	endfunction

	function automatic word_t big_sigma0(input word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic word_t big_sigma1(input word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	// Schedule sigmas end in a plain shift
	function automatic word_t small_sigma0(input word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t small_sigma1(input word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

endpackage

`default_nettype wire

// ==== design/sha256_round.sv ====
/*
 * One SHA-256 compression round with its pipeline register.
 * ROUND_IDX selects the round constant.
 */

`default_nettype none

module sha256_round import sha256_pkg::*; #(
	parameter int ROUND_IDX = 0
) (
	input  wire    CLK,
	input  wire    RST,
	input  logic   write_en_i,
	input  state_t state_i,
	input  word_t  w_i,
	output state_t state_o
);

	word_t  ch;
	word_t  maj;
	word_t  t1;
	word_t  t2;
	state_t state_next;
	state_t state_q;

	assign ch  = (state_i.e & state_i.f) ^ (~state_i.e & state_i.g);
	assign maj = (state_i.a & state_i.b) ^ (state_i.a & state_i.c) ^ (state_i.b & state_i.c);

	assign t1 = state_i.h + big_sigma1(state_i.e) + ch + round_k(ROUND_IDX) + w_i;
	assign t2 = big_sigma0(state_i.a) + maj;

	// Shift the working variables down by one
	assign state_next.a = t1 + t2;
	assign state_next.b = state_i.a;
	assign state_next.c = state_i.b;
	assign state_next.d = state_i.c;
	assign state_next.e = state_i.d + t1;
	assign state_next.f = state_i.e;
	assign state_next.g = state_i.f;
	assign state_next.h = state_i.g;

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			state_q <= '0;
		end else if (write_en_i) begin
			state_q <= state_next;
		end
	end

	assign state_o = state_q;

endmodule

`default_nettype wire

// ==== design/sha256_sched.sv ====
/*
 * Sliding-window message schedule stage.
 * Drops the oldest word and appends the next expanded word each advance.
 */

`default_nettype none

module sha256_sched import sha256_pkg::*; (
	input  wire     CLK,
	input  wire     RST,
	input  logic    write_en_i,
	input  window_t window_i,
	output window_t window_o
);

	word_t   w_new;
	window_t window_next;
	window_t window_q;

	// W[t] from W[t-2], W[t-7], W[t-15] and W[t-16]
	assign w_new = small_sigma1(window_i[14]) + window_i[9]
		+ small_sigma0(window_i[1]) + window_i[0];

	assign window_next = {w_new, window_i[15:1]};

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			window_q <= '0;
		end else if (write_en_i) begin
			window_q <= window_next;
		end
	end

	assign window_o = window_q;

endmodule

`default_nettype wire

// ==== design/sha256_out_ctrl.sv ====
/*
 * Output stage of the pipeline.
 * Counts advances until the pipeline is full, then captures the last
 * round state on every advance and raises valid for good.
 */

`default_nettype none

`include "sha256_defines.svh"

module sha256_out_ctrl import sha256_pkg::*; (
	input  wire    CLK,
	input  wire    RST,
	input  logic   write_en_i,
	input  state_t state_i,
	output state_t digest_o,
	output logic   valid_o
);

	localparam int CNT_W = $clog2(`SHA_ROUNDS + 1);

	logic [CNT_W-1:0] fill_cnt;
	logic             full;
	state_t           digest_q;
	logic             valid_q;

	assign full = (fill_cnt == CNT_W'(`SHA_ROUNDS));

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			fill_cnt <= '0;
			digest_q <= '0;
			valid_q  <= 1'b0;
		end else if (write_en_i) begin
			if (full) begin
				digest_q <= state_i;
				valid_q  <= 1'b1;
			end else begin
				// Still filling
				fill_cnt <= fill_cnt + 1'b1;
			end
		end
	end

	assign digest_o = digest_q;
	assign valid_o  = valid_q;

endmodule

`default_nettype wire

// ==== design/sha256_core.sv ====
/*
 * Fully unrolled SHA-256 compression pipeline for the second header hash.
 * Pads the 256-bit message on chip and returns the raw working state
 * after SHA_ROUNDS rounds, one result per advance once full.
 */

`default_nettype none

`include "sha256_defines.svh"

module sha256_core import sha256_pkg::*; (
	input  wire    CLK,
	input  wire    RST,
	input  logic   write_en_i,
	input  state_t digest_i,
	input  msg_t   block_i,
	output state_t digest_o,
	output logic   valid_o
);

	// chain_state[i] feeds round i, the last entry feeds the output stage
	state_t  chain_state [`SHA_ROUNDS+1];
	window_t win         [`SHA_ROUNDS];

	// Single padded block: message, pad word, zeros, bit length
	assign win[0] = {
		`SHA_LEN_WORD,
		{(6 * `SHA_WORD_W){1'b0}},
		`SHA_PAD_WORD,
		block_i
	};

	assign chain_state[0] = digest_i;

	for (genvar i = 0; i < `SHA_ROUNDS; i++) begin : g_stage
		sha256_round #(
			.ROUND_IDX (i)
		) round_i (
			.CLK        (CLK),
			.RST        (RST),
			.write_en_i (write_en_i),
			.state_i    (chain_state[i]),
			.w_i        (win[i][0]),
			.state_o    (chain_state[i+1])
		);

		// Last round needs no further window
		if (i < `SHA_ROUNDS - 1) begin : g_sched
			sha256_sched sched_i (
				.CLK        (CLK),
				.RST        (RST),
				.write_en_i (write_en_i),
				.window_i   (win[i]),
				.window_o   (win[i+1])
			);
		end
	end

	sha256_out_ctrl out_ctrl_i (
		.CLK        (CLK),
		.RST        (RST),
		.write_en_i (write_en_i),
		.state_i    (chain_state[`SHA_ROUNDS]),
		.digest_o   (digest_o),
		.valid_o    (valid_o)
	);

endmodule

`default_nettype wire

// ==== sim/sha256_core_sva.sv ====
/*
 * Concurrent assertions on the core's output ports, bound to sha256_core.
 */

`default_nettype none

module sha256_core_sva import sha256_pkg::*; (
	input wire    CLK,
	input wire    RST,
	input logic   write_en_i,
	input state_t digest_o,
	input logic   valid_o
);

	timeunit 1ns;
	timeprecision 1ps;

	// Valid is sticky once the pipeline has filled
	a_valid_sticky: assert property (@(posedge CLK) disable iff (!RST)
		valid_o |=> valid_o)
		else $error("valid_o dropped after being set");

	a_hold_on_stall: assert property (@(posedge CLK) disable iff (!RST)
		!write_en_i |=> ($stable(digest_o) && $stable(valid_o)))
		else $error("outputs changed while write_en_i was low");

	a_zero_until_valid: assert property (@(posedge CLK) disable iff (!RST)
		!valid_o |-> (digest_o == '0))
		else $error("digest_o not zero while valid_o is low");

endmodule

bind sha256_core sha256_core_sva sva_i (
	.CLK        (CLK),
	.RST        (RST),
	.write_en_i (write_en_i),
	.digest_o   (digest_o),
	.valid_o    (valid_o)
);

`default_nettype wire

// ==== sim/sha256_ref_model.svh ====
/*
 * Behavioral model of the core: single-block padding of a 256-bit message
 * followed by SHA_ROUNDS compression rounds, with no feed-forward.
 */

`ifndef SHA256_REF_MODEL_SVH
`define SHA256_REF_MODEL_SVH

localparam logic [31:0] MODEL_K [64] = '{
	32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
	32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
	32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
	32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
	32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
	32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
	32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
	32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
	32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
	32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
	32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
	32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
	32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
	32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
	32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
	32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
};

function automatic logic [31:0] ror32(input logic [31:0] x, input int n);
	return (x >> n) | (x << (32 - n));
endfunction

function automatic state_t model_hash(input state_t init, input msg_t msg);
	logic [31:0] w [64];
	logic [31:0] a, b, c, d, e, f, g, h;
	logic [31:0] s0, s1, t1, t2;
	state_t      res;
	for (int i = 0; i < 8; i++) begin
		w[i] = msg[i];
	end
	// Pad word, six zero words, then the bit length
	w[8] = 32'h80000000;
	for (int i = 9; i < 15; i++) begin
		w[i] = 32'h0;
	end
	w[15] = 32'd256;
	for (int i = 16; i < 64; i++) begin
		s0 = ror32(w[i-15], 7) ^ ror32(w[i-15], 18) ^ (w[i-15] >> 3);
		s1 = ror32(w[i-2], 17) ^ ror32(w[i-2], 19) ^ (w[i-2] >> 10);
		w[i] = w[i-16] + s0 + w[i-7] + s1;
	end
	a = init.a;
	b = init.b;
	c = init.c;
	d = init.d;
	e = init.e;
	f = init.f;
	g = init.g;
	h = init.h;
	for (int r = 0; r < `SHA_ROUNDS; r++) begin
		s1 = ror32(e, 6) ^ ror32(e, 11) ^ ror32(e, 25);
		t1 = h + s1 + ((e & f) ^ (~e & g)) + MODEL_K[r] + w[r];
		s0 = ror32(a, 2) ^ ror32(a, 13) ^ ror32(a, 22);
		t2 = s0 + ((a & b) ^ (a & c) ^ (b & c));
		h = g;
		g = f;
		f = e;
		e = d + t1;
		d = c;
		c = b;
		b = a;
		a = t1 + t2;
	end
	res.a = a;
	res.b = b;
	res.c = c;
	res.d = d;
	res.e = e;
	res.f = f;
	res.g = g;
	res.h = h;
	return res;
endfunction

`endif

// ==== sim/sha256_core_tb.sv ====
/*
 * Directed testbench for the pipelined SHA-256 core.
 * Each advance queues a model result that is checked once the pipe is full.
 */

`default_nettype none

`include "sha256_defines.svh"

module sha256_core_tb import sha256_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// About 750 test cycles with ample margin
	localparam int TIMEOUT_CYCLES = 2000;

	logic   CLK;
	logic   RST;
	logic   write_en;
	state_t digest_in;
	msg_t   block_in;
	state_t digest_out;
	logic   valid_out;

	state_t expect_q [$];
	int     adv_cnt = 0;
	int     cycle_cnt = 0;
	string  test_name = "init";

	`include "sha256_ref_model.svh"

	sha256_core sha256_core_i (
		.CLK        (CLK),
		.RST        (RST),
		.write_en_i (write_en),
		.digest_i   (digest_in),
		.block_i    (block_in),
		.digest_o   (digest_out),
		.valid_o    (valid_out)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	task automatic stop_on_error();
		$display("Something failed");
		$fatal(1, "Simulation stopped on error");
	endtask

	always @(posedge CLK) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_on_error();
		end
	end

	task automatic check_state(input state_t exp_val, input state_t act_val);
		if (act_val !== exp_val) begin
			$display("FAIL %s: expected %h, actual %h", test_name, exp_val, act_val);
			stop_on_error();
		end
	endtask

	task automatic check_bit(input logic exp_val, input logic act_val);
		if (act_val !== exp_val) begin
			$display("FAIL %s: expected %b, actual %b", test_name, exp_val, act_val);
			stop_on_error();
		end
	endtask

	function automatic msg_t rand_msg();
		msg_t m;
		for (int i = 0; i < `SHA_MSG_WORDS; i++) begin
			m[i] = $urandom;
		end
		return m;
	endfunction

	function automatic state_t rand_state();
		return state_t'(rand_msg());
	endfunction

	// Drive one cycle, then check the outputs 1 ns after the edge
	task automatic run_cycle(input logic we, input state_t dig, input msg_t msg);
		state_t prev_digest;
		logic   prev_valid;
		prev_digest = digest_out;
		prev_valid  = valid_out;
		write_en    = we;
		digest_in   = dig;
		block_in    = msg;
		if (we) begin
			expect_q.push_back(model_hash(dig, msg));
		end
		@(posedge CLK);
		#1;
		if (we) begin
			adv_cnt++;
			if (adv_cnt > `SHA_ROUNDS) begin
				check_state(expect_q.pop_front(), digest_out);
			end else begin
				check_state('0, digest_out);
			end
			check_bit(adv_cnt > `SHA_ROUNDS, valid_out);
		end else begin
			check_state(prev_digest, digest_out);
			check_bit(prev_valid, valid_out);
		end
	endtask

	task automatic test_reset();
		test_name = "test_reset";
		check_bit(1'b0, valid_out);
		check_state('0, digest_out);
		// Stalls while filling must not move the fill count
		repeat (`SHA_ROUNDS) begin
			run_cycle(1'b1, rand_state(), rand_msg());
			run_cycle(1'b0, rand_state(), rand_msg());
		end
	endtask

	task automatic test_single_vector();
		state_t iv;
		msg_t   msg;
		test_name = "test_single_vector";
		iv = '{32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
			32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19};
		for (int i = 0; i < `SHA_MSG_WORDS; i++) begin
			msg[i] = 32'h01234567 * (i + 1) ^ 32'hdeadbeef;
		end
		run_cycle(1'b1, iv, msg);
		// Push the vector through to the output
		repeat (`SHA_ROUNDS) run_cycle(1'b1, rand_state(), rand_msg());
	endtask

	task automatic test_stream();
		test_name = "test_stream";
		repeat (100) run_cycle(1'b1, rand_state(), rand_msg());
	endtask

	task automatic test_stall();
		int gap;
		test_name = "test_stall";
		repeat (80) begin
			gap = $urandom_range(4, 0);
			repeat (gap) run_cycle(1'b0, rand_state(), rand_msg());
			run_cycle(1'b1, rand_state(), rand_msg());
		end
	endtask

	task automatic test_valid_hold();
		test_name = "test_valid_hold";
		check_bit(1'b1, valid_out);
		repeat (150) run_cycle(1'b0, rand_state(), rand_msg());
		repeat (70) run_cycle(1'b1, rand_state(), rand_msg());
		check_bit(1'b1, valid_out);
	endtask

	initial begin
		RST       = 1'b0;
		write_en  = 1'b0;
		digest_in = '0;
		block_in  = '0;
		void'($urandom(32'h6a8b047c));
		repeat (2) @(posedge CLK);
		#1;
		RST = 1'b1;
		test_reset();
		test_single_vector();
		test_stream();
		test_stall();
		test_valid_hold();
		// One block per stage still in flight
		if (expect_q.size() == `SHA_ROUNDS) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("Scoreboard holds %0d entries instead of %0d",
				expect_q.size(), `SHA_ROUNDS);
			stop_on_error();
		end
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+design
+incdir+sim
design/sha256_pkg.sv
design/sha256_round.sv
design/sha256_sched.sv
design/sha256_out_ctrl.sv
design/sha256_core.sv
sim/sha256_core_sva.sv
sim/sha256_core_tb.sv
